//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps
TOP      = system_tb
FILELIST = sim.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- common/isa_pkg.sv
package isa_pkg;

    // Data path and instruction word width
    localparam int word_width = 16;

    // Instruction field widths
    localparam int opcode_width = 4;
    localparam int operand_width = 5;
    localparam int spare_width = word_width - opcode_width - operand_width;

    // Opcode encodings, zero is left undefined so blank memory halts
    typedef enum logic [opcode_width-1:0] {
        op_load  = 4'h1,
        op_store = 4'h2,
        op_add   = 4'h3,
        op_sub   = 4'h4,
        op_jump  = 4'h5,
        op_jz    = 4'h6,
        op_halt  = 4'h7
    } opcode_t;

    // Instruction word layout, opcode in the top nibble
    typedef struct packed {
        opcode_t                  opcode;
        logic [spare_width-1:0]   unused;
        logic [operand_width-1:0] addr;
    } instr_t;

endpackage

//--- common/program.hex
// One 16-bit hex word per line for addresses 0 to 31
// Opcode in the top nibble and operand address in the low 5 bits
1015 // LOAD 21
3014 // ADD 20
2015 // STORE 21
1014 // LOAD 20
4016 // SUB 22
2014 // STORE 20
6008 // JZ 8
5000 // JUMP 0
1015 // LOAD 21
7000 // HALT
0000
0000
0000
0000
0000
0000
0000
0000
0000
0000
000A // counter, starts at 10
0000 // running sum
0001 // decrement step
0000
0000
0000
0000
0000
0000
0000
0000
0000

//--- common/system_pkg.sv
package system_pkg;

    import isa_pkg::*;

    // RAM geometry
    localparam int mem_depth = 32;
    localparam int addr_width = $clog2(mem_depth);

    // Request presented to the shared memory port
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [word_width-1:0] wdata;
        logic                  write;
    } mem_req_t;

    // Top level control states
    typedef enum logic [1:0] {
        st_idle,
        st_loading,
        st_executing,
        st_halted
    } system_state_t;

    // Program image read by the loader
    localparam string program_file = "common/program.hex";

endpackage

//--- cpu/cpu_core.sv
`timescale 1ns/1ps

module cpu_core
    import isa_pkg::*, system_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start_execution,
    input  logic [word_width-1:0] rdata,
    output mem_req_t              mem_req,
    output logic [word_width-1:0] acc,
    output logic                  halted
);

    typedef enum logic [1:0] {
        cpu_fetch,
        cpu_decode,
        cpu_execute
    } cpu_state_t;

    cpu_state_t            cpu_state;
    logic [addr_width-1:0] pc;
    instr_t                ir;
    instr_t                fetched;
    logic                  run;

    // Word returned for the fetch address, valid in decode
    assign fetched = instr_t'(rdata);

    // Everything freezes once halted or while the controller holds us off
    assign run = start_execution && !halted;

    // Memory port: pc during fetch, operand address during decode
    always_comb begin
        mem_req.addr = pc;
        mem_req.wdata = acc;
        mem_req.write = 1'b0;
        if (cpu_state == cpu_decode) begin
            mem_req.addr = fetched.addr;
            mem_req.write = run && (fetched.opcode == op_store);
        end
    end

    // Sequencer and architectural state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cpu_state <= cpu_fetch;
            pc <= '0;
            acc <= '0;
            halted <= 1'b0;
        end else if (run) begin
            case (cpu_state)
                cpu_fetch: begin
                    cpu_state <= cpu_decode;
                end

                cpu_decode: begin
                    cpu_state <= cpu_fetch;
                    case (fetched.opcode)
                        // Operand read issued this cycle, result lands in execute
                        op_load, op_add, op_sub: begin
                            cpu_state <= cpu_execute;
                        end
                        op_store: begin
                            pc <= pc + 1'b1;
                        end
                        op_jump: begin
                            pc <= fetched.addr;
                        end
                        op_jz: begin
                            if (acc == '0) begin
                                pc <= fetched.addr;
                            end else begin
                                pc <= pc + 1'b1;
                            end
                        end
                        op_halt: begin
                            halted <= 1'b1;
                        end
                        // Undefined opcodes stop the machine as well
                        default: begin
                            halted <= 1'b1;
                        end
                    endcase
                end

                cpu_execute: begin
                    case (ir.opcode)
                        op_load: acc <= rdata;
                        op_add:  acc <= acc + rdata;
                        op_sub:  acc <= acc - rdata;
                        default: acc <= acc;
                    endcase
                    pc <= pc + 1'b1;
                    cpu_state <= cpu_fetch;
                end

                default: begin
                    cpu_state <= cpu_fetch;
                end
            endcase
        end
    end

    // Instruction register, only read back in execute
    always_ff @(posedge clock) begin
        if (run && cpu_state == cpu_decode) begin
            ir <= fetched;
        end
    end

endmodule

//--- logic/memory.sv
`timescale 1ns/1ps

module memory
    import isa_pkg::*, system_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  mem_req_t              req,
    output logic [word_width-1:0] rdata
);

    logic [word_width-1:0] ram [mem_depth];

    // Write port, contents survive reset
    always_ff @(posedge clock) begin
        if (req.write) begin
            ram[req.addr] <= req.wdata;
        end
    end

    // Registered read, returns the old word on a same-cycle write
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rdata <= '0;
        end else begin
            rdata <= ram[req.addr];
        end
    end

endmodule

//--- logic/program_loader.sv
`timescale 1ns/1ps

module program_loader
    import isa_pkg::*, system_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     start_load,
    output logic     load_complete,
    output mem_req_t mem_req
);

    logic [word_width-1:0] rom [mem_depth];
    logic [addr_width-1:0] count;

    // Fixed program image
    initial begin
        $readmemh(program_file, rom);
    end

    // Word counter, restarts from zero whenever loading is not requested
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (!start_load) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // High during the write of the last word
    assign load_complete = start_load && (count == addr_width'(mem_depth - 1));

    // One write per cycle while loading
    always_comb begin
        mem_req.addr = count;
        mem_req.wdata = rom[count];
        mem_req.write = start_load;
    end

endmodule

//--- logic/system.sv
`timescale 1ns/1ps

module system
    import isa_pkg::*, system_pkg::*;
(
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    output system_state_t         state,
    output logic                  halted,
    output logic [word_width-1:0] acc
);

    logic                  start_load;
    logic                  load_complete;
    logic                  start_execution;
    logic [word_width-1:0] rdata;
    mem_req_t              cpu_req;
    mem_req_t              loader_req;
    mem_req_t              mem_req;

    cpu_core cpu_core_inst (
        .clock           (clock),
        .reset           (reset),
        .start_execution (start_execution),
        .rdata           (rdata),
        .mem_req         (cpu_req),
        .acc             (acc),
        .halted          (halted)
    );

    memory memory_inst (
        .clock (clock),
        .reset (reset),
        .req   (mem_req),
        .rdata (rdata)
    );

    program_loader program_loader_inst (
        .clock         (clock),
        .reset         (reset),
        .start_load    (start_load),
        .load_complete (load_complete),
        .mem_req       (loader_req)
    );

    assign start_load = (state == st_loading);

    // Loader owns the RAM only while loading
    assign mem_req = start_load ? loader_req : cpu_req;

    // Control FSM
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            start_execution <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_loading;
                    end
                end

                st_loading: begin
                    if (load_complete) begin
                        state <= st_executing;
                        start_execution <= 1'b1;
                    end
                end

                st_executing: begin
                    if (halted) begin
                        state <= st_halted;
                        start_execution <= 1'b0;
                    end
                end

                // Terminal until the next reset
                default: begin
                    start_execution <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- sim.f
common/isa_pkg.sv
common/system_pkg.sv
cpu/cpu_core.sv
logic/memory.sv
logic/program_loader.sv
logic/system.sv
test/system_tb.sv

//--- test/system_tb.sv
`timescale 1ns/1ps

module system_tb
    import isa_pkg::*, system_pkg::*;
();

    typedef enum logic [1:0] {
        act_start,
        act_reset,
        act_wait
    } action_t;

    // One step of the table, its name sits in step_names at the same index
    typedef struct packed {
        action_t               action;
        logic [15:0]           cycles;
        system_state_t         exp_state;
        logic                  exp_halted;
        logic [word_width-1:0] exp_acc;
        logic                  acc_dont_care;
    } step_t;

    localparam int reset_cycles = 4;
    localparam int margin_cycles = 100;
    localparam logic acc_any = 1'b1;
    localparam logic acc_exact = 1'b0;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  start;
    system_state_t         state;
    logic                  halted;
    logic [word_width-1:0] acc;

    step_t step_table[$];
    string step_names[$];
    int    cycle_count = 0;
    int    cycle_limit;

    system system_inst (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .state  (state),
        .halted (halted),
        .acc    (acc)
    );

    always #10 clock = ~clock;

    // Run length guard
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles before the step table finished", cycle_limit);
            $display("Something failed");
            $fatal(1, "simulation ran too long");
        end
    end

    task automatic check(input string step_name, input string field,
                         input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %0d, actual %0d",
                     step_name, field, expected, actual);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [word_width-1:0] encode(opcode_t op, logic [4:0] addr);
        instr_t instr;
        instr.opcode = op;
        instr.unused = '0;
        instr.addr = addr;
        return instr;
    endfunction

    // Instruction-level model of the summing program with per-opcode cycle costs
    task automatic run_model(output logic [word_width-1:0] result, output int cycles);
        logic [word_width-1:0] image [mem_depth];
        logic [word_width-1:0] acc_m;
        logic [4:0]            pc_m;
        instr_t                instr;
        logic                  done;
        int                    steps;
        for (int i = 0; i < mem_depth; i++) begin
            image[i] = '0;
        end
        image[0] = encode(op_load, 5'd21);
        image[1] = encode(op_add, 5'd20);
        image[2] = encode(op_store, 5'd21);
        image[3] = encode(op_load, 5'd20);
        image[4] = encode(op_sub, 5'd22);
        image[5] = encode(op_store, 5'd20);
        image[6] = encode(op_jz, 5'd8);
        image[7] = encode(op_jump, 5'd0);
        image[8] = encode(op_load, 5'd21);
        image[9] = encode(op_halt, 5'd0);
        image[20] = 16'd10;
        image[22] = 16'd1;
        acc_m = '0;
        pc_m = '0;
        cycles = 0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 10000) begin
            instr = instr_t'(image[pc_m]);
            steps++;
            case (instr.opcode)
                op_load: begin
                    acc_m = image[instr.addr];
                    pc_m = pc_m + 5'd1;
                    cycles += 3;
                end
                op_add: begin
                    acc_m = acc_m + image[instr.addr];
                    pc_m = pc_m + 5'd1;
                    cycles += 3;
                end
                op_sub: begin
                    acc_m = acc_m - image[instr.addr];
                    pc_m = pc_m + 5'd1;
                    cycles += 3;
                end
                op_store: begin
                    image[instr.addr] = acc_m;
                    pc_m = pc_m + 5'd1;
                    cycles += 2;
                end
                op_jump: begin
                    pc_m = instr.addr;
                    cycles += 2;
                end
                op_jz: begin
                    pc_m = (acc_m == '0) ? instr.addr : pc_m + 5'd1;
                    cycles += 2;
                end
                // HALT and undefined opcodes
                default: begin
                    done = 1'b1;
                    cycles += 2;
                end
            endcase
        end
        result = acc_m;
    endtask

    task automatic add_step(input string name, input action_t action, input int cycles,
                            input system_state_t exp_state, input logic exp_halted,
                            input logic [word_width-1:0] exp_acc, input logic acc_dont_care);
        step_t step;
        step.action = action;
        step.cycles = 16'(cycles);
        step.exp_state = exp_state;
        step.exp_halted = exp_halted;
        step.exp_acc = exp_acc;
        step.acc_dont_care = acc_dont_care;
        step_table.push_back(step);
        step_names.push_back(name);
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic apply_step(input step_t step);
        case (step.action)
            act_start: begin
                start = 1'b1;
                next_cycle();
                start = 1'b0;
            end
            act_reset: begin
                reset = 1'b1;
                next_cycle();
                reset = 1'b0;
            end
            default: begin
                repeat (step.cycles) next_cycle();
            end
        endcase
    endtask

    initial begin
        logic [word_width-1:0] model_acc;
        int                    run_cycles;
        int                    total;
        step_t                 step;
        reset = 1'b1;
        start = 1'b0;
        run_model(model_acc, run_cycles);

        // First run up to halt and a start strobe that must be ignored
        add_step("after_reset", act_wait, 0, st_idle, 1'b0, 16'd0, acc_exact);
        add_step("idle_wait", act_wait, 10, st_idle, 1'b0, 16'd0, acc_exact);
        add_step("start_load", act_start, 1, st_loading, 1'b0, 16'd0, acc_exact);
        add_step("load_busy", act_wait, 31, st_loading, 1'b0, 16'd0, acc_exact);
        add_step("load_done", act_wait, 1, st_executing, 1'b0, 16'd0, acc_exact);
        add_step("halt_raised", act_wait, run_cycles, st_executing, 1'b1, model_acc,
                 acc_exact);
        add_step("halted_state", act_wait, 1, st_halted, 1'b1, model_acc, acc_exact);
        add_step("start_in_halted", act_start, 1, st_halted, 1'b1, model_acc, acc_exact);

        // Second run with a start strobe during execution
        add_step("reset_after_halt", act_reset, 1, st_idle, 1'b0, 16'd0, acc_exact);
        add_step("second_start", act_start, 1, st_loading, 1'b0, 16'd0, acc_exact);
        add_step("second_loaded", act_wait, 32, st_executing, 1'b0, 16'd0, acc_exact);
        add_step("second_mid_run", act_wait, 50, st_executing, 1'b0, 16'd0, acc_any);
        add_step("start_in_exec", act_start, 1, st_executing, 1'b0, 16'd0, acc_any);
        add_step("second_halted", act_wait, run_cycles + 1 - 51, st_halted, 1'b1,
                 model_acc, acc_exact);

        // Third run cut short by reset and followed by a full reload and run
        add_step("reset_second", act_reset, 1, st_idle, 1'b0, 16'd0, acc_exact);
        add_step("third_start", act_start, 1, st_loading, 1'b0, 16'd0, acc_exact);
        add_step("third_loaded", act_wait, 32, st_executing, 1'b0, 16'd0, acc_exact);
        add_step("third_mid_run", act_wait, 100, st_executing, 1'b0, 16'd0, acc_any);
        add_step("reset_in_exec", act_reset, 1, st_idle, 1'b0, 16'd0, acc_exact);
        add_step("idle_after_reset", act_wait, 5, st_idle, 1'b0, 16'd0, acc_exact);
        add_step("reload_start", act_start, 1, st_loading, 1'b0, 16'd0, acc_exact);
        add_step("reload_done", act_wait, 32, st_executing, 1'b0, 16'd0, acc_exact);
        // A stale image from the cut run would halt early with the same sum
        add_step("reload_halt_raised", act_wait, run_cycles, st_executing, 1'b1,
                 model_acc, acc_exact);
        add_step("reload_halted", act_wait, 1, st_halted, 1'b1, model_acc, acc_exact);

        total = reset_cycles + margin_cycles;
        for (int i = 0; i < step_table.size(); i++) begin
            total += (step_table[i].action == act_wait) ? int'(step_table[i].cycles) : 1;
        end
        cycle_limit = total;

        repeat (reset_cycles) @(posedge clock);
        #2;
        reset = 1'b0;

        for (int i = 0; i < step_table.size(); i++) begin
            step = step_table[i];
            apply_step(step);
            check(step_names[i], "state", 32'(step.exp_state), 32'(state));
            check(step_names[i], "halted", 32'(step.exp_halted), 32'(halted));
            if (!step.acc_dont_care) begin
                check(step_names[i], "acc", 32'(step.exp_acc), 32'(acc));
            end
        end

        $display("Everything OK");
        $finish;
    end

endmodule
